//--- Bender.yml
package:
  name: mips_uniciclo

sources:
  - files:
      - source/mips_pkg.sv
      - source/control_unit.sv
      - source/register_bank.sv
      - source/alu.sv
      - source/muu.sv
      - source/program_counter.sv
      - source/data_memory.sv
      - source/inst_memory.sv
      - source/mips_uniciclo.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mips_uniciclo.sv

//--- mips_uniciclo.f
+incdir+tests
source/mips_pkg.sv
source/control_unit.sv
source/register_bank.sv
source/alu.sv
source/muu.sv
source/program_counter.sv
source/data_memory.sv
source/inst_memory.sv
source/mips_uniciclo.sv
tests/tb_mips_uniciclo.sv

//--- source/alu.sv
`default_nettype none

module alu import mips_pkg::*; (
	input  wire logic [31:0] a,
	input  wire logic [31:0] b,
	input  wire alu_op_e     op,
	input  wire logic        is_movn,
	output      logic [31:0] result,
	output      logic        zero,
	output      logic        movn_skip
);

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_slt:    result = {31'b0, $signed(a) < $signed(b)};	// Signed compare
			alu_lui:    result = {b[15:0], 16'b0};
			alu_pass_a: result = a;					// movn source
			default:    result = a + b;
		endcase
	end

	assign zero = (result == 32'd0);				// Equal operands on sub

	// movn with a zero rt leaves rd untouched
	assign movn_skip = is_movn && (b == 32'd0);

endmodule

`default_nettype wire

//--- source/control_unit.sv
`default_nettype none

module control_unit import mips_pkg::*; (
	input  instr_u instr,
	output ctrl_t  ctrl
);

	always_comb begin
		ctrl = '0;							// No-op unless decoded below
		case (instr.r.op)
			op_rtype: begin
				ctrl.reg_dst = dst_rd;
				case (instr.r.funct)
					fn_add:  ctrl.reg_we = 1'b1;
					fn_sub: begin
						ctrl.alu_op = alu_sub;
						ctrl.reg_we = 1'b1;
					end
					fn_and: begin
						ctrl.alu_op = alu_and;
						ctrl.reg_we = 1'b1;
					end
					fn_or: begin
						ctrl.alu_op = alu_or;
						ctrl.reg_we = 1'b1;
					end
					fn_slt: begin
						ctrl.alu_op = alu_slt;
						ctrl.reg_we = 1'b1;
					end
					fn_jr:   ctrl.pc_src = pc_reg;		// Jump to rs
					fn_mult: ctrl.muu_op = muu_mult;	// Result lands in hi/lo only
					fn_div:  ctrl.muu_op = muu_div;
					fn_mfhi: begin
						ctrl.wb_src = wb_muu;
						ctrl.muu_hi = 1'b1;
						ctrl.reg_we = 1'b1;
					end
					fn_mflo: begin
						ctrl.wb_src = wb_muu;
						ctrl.reg_we = 1'b1;
					end
					fn_movn: begin
						ctrl.alu_op  = alu_pass_a;	// rd gets rs
						ctrl.is_movn = 1'b1;		// Write dropped when rt is zero
						ctrl.reg_we  = 1'b1;
					end
					default: ;
				endcase
			end
			op_addi, op_slti: begin
				ctrl.alu_op      = (instr.i.op == op_slti) ? alu_slt : alu_add;
				ctrl.alu_src_imm = 1'b1;
				ctrl.imm_signed  = 1'b1;
				ctrl.reg_we      = 1'b1;
			end
			op_andi, op_ori, op_lui: begin	// Zero extended immediates
				case (instr.i.op)
					op_andi: ctrl.alu_op = alu_and;
					op_ori:  ctrl.alu_op = alu_or;
					default: ctrl.alu_op = alu_lui;
				endcase
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_we      = 1'b1;
			end
			op_lw, op_lb, op_sw, op_sb: begin
				ctrl.alu_src_imm = 1'b1;			// Address is rs + offset
				ctrl.imm_signed  = 1'b1;
				ctrl.mem_byte    = (instr.i.op == op_lb) || (instr.i.op == op_sb);
				ctrl.mem_we      = (instr.i.op == op_sw) || (instr.i.op == op_sb);
				ctrl.reg_we      = (instr.i.op == op_lw) || (instr.i.op == op_lb);
				ctrl.wb_src      = wb_mem;
			end
			op_beq, op_bne: begin
				ctrl.alu_op     = alu_sub;			// Compare by subtraction
				ctrl.imm_signed = 1'b1;
				ctrl.pc_src     = pc_branch;
				ctrl.branch_ne  = (instr.i.op == op_bne);
			end
			op_j:    ctrl.pc_src = pc_jump;
			op_jal: begin
				ctrl.pc_src  = pc_jump;
				ctrl.reg_dst = dst_ra;				// Link into r31
				ctrl.wb_src  = wb_ret;
				ctrl.reg_we  = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/data_memory.sv
`default_nettype none

module data_memory import mips_pkg::*; (
	input  wire logic                   clk,
	input  wire logic [dmem_addr_w-1:0] addr,
	input  wire logic                   wr_en,
	input  wire logic                   byte_mode,
	input  wire logic [31:0]            wr_data,
	output      logic [31:0]            rd_data
);

	logic [31:0] mem [dmem_words];
	logic [31:0] wr_word;
	logic [31:0] rd_word;

	// Byte filter on the write side, upper bytes cleared
	assign wr_word = byte_mode ? {24'b0, wr_data[7:0]} : wr_data;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[addr] <= wr_word;
		end
	end

	assign rd_word = mem[addr];					// Asynchronous read
	assign rd_data = byte_mode ? {24'b0, rd_word[7:0]} : rd_word;	// Read-side filter

endmodule

`default_nettype wire

//--- source/inst_memory.sv
`default_nettype none

module inst_memory import mips_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   prog_we,
	input  wire logic [imem_addr_w-1:0] prog_addr,
	input  wire logic [31:0]            prog_data,
	input  wire logic [imem_addr_w-1:0] fetch_addr,
	output      instr_u                 instr
);

	logic [31:0] mem [imem_words];

	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;			// Program load, one word per edge
		end
	end

	assign instr = mem[fetch_addr];				// Fetch settles in the same cycle

endmodule

`default_nettype wire

//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int imem_words  = 32;
	localparam int dmem_words  = 32;
	localparam int imem_addr_w = $clog2(imem_words);	// Word index into instruction RAM
	localparam int dmem_addr_w = $clog2(dmem_words);	// Word index into data RAM

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lb    = 6'h20,
		op_lw    = 6'h23,
		op_sb    = 6'h28,
		op_sw    = 6'h2b
	} op_e;

	typedef enum logic [5:0] {
		fn_jr   = 6'h08,
		fn_movn = 6'h0b,
		fn_mfhi = 6'h10,
		fn_mflo = 6'h12,
		fn_mult = 6'h18,
		fn_div  = 6'h1a,
		fn_add  = 6'h20,
		fn_sub  = 6'h22,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_lui,
		alu_pass_a				// Forwards rs for movn
	} alu_op_e;

	typedef enum logic [1:0] {muu_none, muu_mult, muu_div} muu_op_e;
	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_reg} pc_src_e;
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_ret, wb_muu} wb_src_e;
	typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} reg_dst_e;

	typedef struct packed {
		op_e        op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		op_e         op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		op_e         op;
		logic [25:0] target26;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;				// Register format
		i_fmt_t i;				// Immediate format
		j_fmt_t j;				// Jump format
	} instr_u;

	typedef struct packed {
		reg_dst_e reg_dst;		// Destination register select
		wb_src_e  wb_src;		// Write-back source
		pc_src_e  pc_src;		// Next PC source
		logic     branch_ne;	// Branch on not equal
		alu_op_e  alu_op;
		logic     alu_src_imm;	// Operand B from immediate
		logic     imm_signed;	// Sign extend imm16
		logic     reg_we;
		logic     mem_we;
		logic     mem_byte;		// Low byte only on memory paths
		logic     is_movn;
		muu_op_e  muu_op;
		logic     muu_hi;		// mfhi rather than mflo
	} ctrl_t;

	typedef struct packed {
		logic        valid;		// Register write committed this cycle
		logic [4:0]  reg_addr;
		logic [31:0] data;
	} retire_t;

endpackage

`default_nettype wire

//--- source/mips_uniciclo.sv
`default_nettype none

module mips_uniciclo import mips_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   prog_we,
	input  wire logic [imem_addr_w-1:0] prog_addr,
	input  wire logic [31:0]            prog_data,
	output      logic [31:0]            pc,
	output      retire_t                retire,
	output      logic [31:0]            hi,
	output      logic [31:0]            lo
);

	instr_u      instr;
	ctrl_t       ctrl;
	logic [31:0] rs_data, rt_data;			// Register bank reads
	logic [31:0] imm_ext;					// Extended imm16
	logic [31:0] operand_b;
	logic [31:0] alu_result;
	logic        alu_zero, movn_skip;
	logic [31:0] mem_data, muu_result, return_address;
	logic [4:0]  wr_addr;
	logic [31:0] wb_data;
	logic        wr_en;

	inst_memory i_inst_memory (
		.clk, .prog_we, .prog_addr, .prog_data,
		.fetch_addr(pc[imem_addr_w+1:2]),		// Word index of the PC
		.instr
	);

	control_unit i_control_unit (.instr, .ctrl);

	register_bank i_register_bank (
		.clk, .rst_n,
		.rs_addr(instr.r.rs), .rt_addr(instr.r.rt), .wr_addr,
		.wr_en, .wr_data(wb_data), .rs_data, .rt_data
	);

	assign imm_ext   = ctrl.imm_signed ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
										: {16'b0, instr.i.imm16};
	assign operand_b = ctrl.alu_src_imm ? imm_ext : rt_data;

	alu i_alu (
		.a(rs_data), .b(operand_b), .op(ctrl.alu_op), .is_movn(ctrl.is_movn),
		.result(alu_result), .zero(alu_zero), .movn_skip
	);

	muu i_muu (
		.clk, .rst_n, .rs_val(rs_data), .rt_val(rt_data),
		.op(ctrl.muu_op), .sel_hi(ctrl.muu_hi), .result(muu_result), .hi, .lo
	);

	data_memory i_data_memory (
		.clk, .addr(alu_result[dmem_addr_w+1:2]), .wr_en(ctrl.mem_we),
		.byte_mode(ctrl.mem_byte), .wr_data(rt_data), .rd_data(mem_data)
	);

	program_counter i_program_counter (
		.clk, .rst_n, .pc_src(ctrl.pc_src), .branch_ne(ctrl.branch_ne), .zero(alu_zero),
		.b_offset(imm_ext), .j_target(instr.j.target26), .reg_target(rs_data),
		.pc, .return_address
	);

	always_comb begin
		case (ctrl.reg_dst)
			dst_rd:  wr_addr = instr.r.rd;
			dst_ra:  wr_addr = 5'd31;			// jal link register
			default: wr_addr = instr.r.rt;
		endcase
		case (ctrl.wb_src)
			wb_mem:  wb_data = mem_data;
			wb_ret:  wb_data = return_address;
			wb_muu:  wb_data = muu_result;
			default: wb_data = alu_result;
		endcase
	end

	assign wr_en = ctrl.reg_we && !movn_skip;		// movn gating

	assign retire.valid    = wr_en && rst_n;		// Nothing retires while held in reset
	assign retire.reg_addr = wr_addr;
	assign retire.data     = wb_data;

endmodule

`default_nettype wire

//--- source/muu.sv
`default_nettype none

module muu import mips_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [31:0] rs_val,
	input  wire logic [31:0] rt_val,
	input  wire muu_op_e     op,
	input  wire logic        sel_hi,
	output      logic [31:0] result,
	output      logic [31:0] hi,
	output      logic [31:0] lo
);

	logic signed [63:0] product;
	logic signed [31:0] quotient;
	logic signed [31:0] remainder;
	logic               div_zero;

	assign product   = $signed(rs_val) * $signed(rt_val);	// Full 64 bit signed product
	assign div_zero  = (rt_val == 32'd0);
	assign quotient  = div_zero ? 32'sd0 : $signed(rs_val) / $signed(rt_val);	// Signed divide
	assign remainder = div_zero ? 32'sd0 : $signed(rs_val) % $signed(rt_val);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			case (op)
				muu_mult: begin
					hi <= product[63:32];
					lo <= product[31:0];
				end
				muu_div: begin
					if (!div_zero) begin			// Divide by zero keeps hi/lo
						hi <= remainder;
						lo <= quotient;
					end
				end
				default: ;
			endcase
		end
	end

	assign result = sel_hi ? hi : lo;				// mfhi / mflo read-out

endmodule

`default_nettype wire

//--- source/program_counter.sv
`default_nettype none

module program_counter import mips_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire pc_src_e     pc_src,
	input  wire logic        branch_ne,
	input  wire logic        zero,
	input  wire logic [31:0] b_offset,
	input  wire logic [25:0] j_target,
	input  wire logic [31:0] reg_target,
	output      logic [31:0] pc,
	output      logic [31:0] return_address
);

	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic        taken;

	assign pc_plus4 = pc + 32'd4;
	assign taken    = zero ^ branch_ne;				// beq on zero, bne on nonzero

	always_comb begin
		case (pc_src)
			pc_branch: next_pc = taken ? pc_plus4 + {b_offset[29:0], 2'b00} : pc_plus4;
			pc_jump:   next_pc = {pc_plus4[31:28], j_target, 2'b00};	// Region jump
			pc_reg:    next_pc = reg_target;			// jr
			default:   next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	assign return_address = pc_plus4;				// Link value for jal

endmodule

`default_nettype wire

//--- source/register_bank.sv
`default_nettype none

module register_bank (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [4:0]  rs_addr,
	input  wire logic [4:0]  rt_addr,
	input  wire logic [4:0]  wr_addr,
	input  wire logic        wr_en,
	input  wire logic [31:0] wr_data,
	output      logic [31:0] rs_data,
	output      logic [31:0] rt_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};			// Whole bank cleared
		end else if (wr_en && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data;		// Writes to r0 are discarded
		end
	end

	// Asynchronous reads, r0 pinned to zero
	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- tests/tb_programs.svh
// Instruction encoders and program images, included inside the testbench module

function automatic logic [31:0] enc_r(funct_e fn, logic [4:0] rs, logic [4:0] rt,
	logic [4:0] rd);
	return {op_rtype, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(op_e op, logic [4:0] rs, logic [4:0] rt,
	logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(op_e op, logic [25:0] target);
	return {op, target};
endfunction

function automatic void emit(logic [31:0] word);
	prog.push_back(word);
endfunction

// lui/ori pair loading a full 32 bit constant
function automatic void plant(logic [4:0] rd, logic [31:0] value);
	emit(enc_i(op_lui, 0, rd, value[31:16]));
	emit(enc_i(op_ori, rd, rd, value[15:0]));
endfunction

function automatic void halt();
	emit(enc_j(op_j, 26'(prog.size())));		// Jump to itself
endfunction

function automatic void arith_program(logic [31:0] x, logic [31:0] y, logic [15:0] k);
	prog.delete();
	plant(1, x);
	plant(2, y);
	emit(enc_r(fn_add, 1, 2, 3));
	emit(enc_r(fn_sub, 1, 2, 4));
	emit(enc_r(fn_and, 1, 2, 5));
	emit(enc_r(fn_or, 1, 2, 6));
	emit(enc_r(fn_slt, 1, 2, 7));			// Signed compare
	emit(enc_i(op_addi, 1, 8, k));
	emit(enc_i(op_slti, 2, 9, k));
	emit(enc_i(op_andi, 1, 10, k));
	emit(enc_i(op_ori, 2, 11, k));
	emit(enc_i(op_lui, 0, 12, k));
	emit(enc_r(fn_add, 1, 2, 0));			// Written to r0 and dropped
	emit(enc_r(fn_add, 0, 1, 13));			// Equals r1 only if r0 still reads zero
	halt();
endfunction

function automatic void memory_program(logic [31:0] x, logic [31:0] y);
	prog.delete();
	plant(1, x);
	plant(2, y);
	emit(enc_i(op_addi, 0, 7, 16'd24));		// Base address
	emit(enc_i(op_sw, 7, 1, 16'hfff8));		// Word 4 via negative offset
	emit(enc_i(op_lw, 0, 3, 16'd16));
	emit(enc_i(op_sb, 7, 2, 16'd0));			// Byte store into word 6
	emit(enc_i(op_lw, 7, 4, 16'd0));
	emit(enc_i(op_sw, 0, 2, 16'd28));
	emit(enc_i(op_lb, 0, 5, 16'd28));		// Low byte of a full word
	emit(enc_i(op_lw, 0, 6, 16'd28));
	halt();
endfunction

// x must be nonzero for the bne against r0
function automatic void flow_program(logic [31:0] x);
	prog.delete();
	plant(1, x);							// Words 0 and 1
	plant(2, x);							// Words 2 and 3, r2 equals r1
	emit(enc_i(op_beq, 1, 2, 1));			// 4 taken
	emit(enc_i(op_addi, 0, 3, 1));			// 5 skipped
	emit(enc_i(op_bne, 1, 2, 1));			// 6 not taken
	emit(enc_i(op_addi, 0, 4, 2));			// 7
	emit(enc_i(op_bne, 1, 0, 1));			// 8 taken
	emit(enc_i(op_addi, 0, 5, 3));			// 9 skipped
	emit(enc_i(op_beq, 1, 0, 1));			// 10 not taken
	emit(enc_i(op_addi, 0, 6, 4));			// 11
	emit(enc_j(op_jal, 15));				// 12 call
	emit(enc_i(op_addi, 0, 7, 5));			// 13 return lands here
	emit(enc_j(op_j, 17));					// 14 over the subroutine
	emit(enc_i(op_addi, 0, 8, 6));			// 15 subroutine body
	emit(enc_r(fn_jr, 31, 0, 0));			// 16 return
	halt();									// 17
endfunction

// y must be nonzero for the first div
function automatic void muu_program(logic [31:0] x, logic [31:0] y);
	prog.delete();
	plant(1, x);
	plant(2, y);
	emit(enc_r(fn_mult, 1, 2, 0));
	emit(enc_r(fn_mfhi, 0, 0, 3));
	emit(enc_r(fn_mflo, 0, 0, 4));
	emit(enc_r(fn_div, 1, 2, 0));
	emit(enc_r(fn_mfhi, 0, 0, 5));
	emit(enc_r(fn_mflo, 0, 0, 6));
	emit(enc_r(fn_div, 2, 0, 0));			// Divide by zero
	emit(enc_r(fn_mfhi, 0, 0, 7));
	emit(enc_r(fn_mflo, 0, 0, 8));
	halt();
endfunction

function automatic void movn_program(logic [31:0] x, logic [31:0] y);
	prog.delete();
	plant(1, x);
	plant(2, y);
	emit(enc_r(fn_movn, 1, 2, 3));			// rt nonzero so r3 gets r1
	emit(enc_r(fn_movn, 1, 0, 4));			// rt zero, no write
	emit(enc_r(fn_add, 4, 0, 5));			// r4 still zero
	halt();
endfunction

function automatic void reset_program(logic [31:0] x, logic [31:0] y);
	prog.delete();
	emit(enc_r(fn_add, 1, 2, 3));			// Reads cleared registers after reset
	plant(1, x);
	plant(2, y);
	emit(enc_r(fn_add, 1, 2, 4));
	halt();
endfunction

//--- tests/tb_mips_uniciclo.sv
`default_nettype none

module tb_mips_uniciclo import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int arith_cycles = 20;
	localparam int mem_cycles   = 15;
	localparam int flow_cycles  = 20;
	localparam int muu_cycles   = 15;
	localparam int movn_cycles  = 10;
	localparam int reset_cycles = 12;		// Both halves of the reset test
	// Seven load and reset phases plus all run cycles, with half again as margin
	localparam int watchdog_cycles = (7 * (imem_words + 6) + arith_cycles + mem_cycles
		+ flow_cycles + muu_cycles + movn_cycles + reset_cycles) * 3 / 2;

	logic                   clk;
	logic                   rst_n;
	logic                   prog_we;
	logic [imem_addr_w-1:0] prog_addr;
	logic [31:0]            prog_data;
	logic [31:0]            pc;
	retire_t                retire;
	logic [31:0]            hi;
	logic [31:0]            lo;

	logic [31:0] prog [$];					// Program image of the current test
	logic [31:0] m_regs [32];				// Reference model state
	logic [31:0] m_dmem [dmem_words];
	logic [31:0] m_hi;
	logic [31:0] m_lo;
	logic [31:0] m_pc;
	int          errors;
	int          tests_run;
	int          tests_failed;

	`include "tb_programs.svh"

	mips_uniciclo i_dut (
		.clk, .rst_n, .prog_we, .prog_addr, .prog_data,
		.pc, .retire, .hi, .lo
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Executes the instruction at m_pc, returns the register write it makes
	function automatic retire_t model_step();
		instr_u                 ins;
		logic [31:0]            a;
		logic [31:0]            b;
		logic [31:0]            simm;
		logic [31:0]            zimm;
		logic [31:0]            addr;
		logic [dmem_addr_w-1:0] widx;
		logic [31:0]            npc;
		retire_t                r;
		ins  = prog[m_pc[imem_addr_w+1:2]];
		a    = m_regs[ins.r.rs];
		b    = m_regs[ins.r.rt];
		simm = {{16{ins.i.imm16[15]}}, ins.i.imm16};
		zimm = {16'b0, ins.i.imm16};
		addr = a + simm;
		widx = addr[dmem_addr_w+1:2];		// Word index
		npc  = m_pc + 32'd4;
		r    = '0;
		case (ins.r.op)
			op_rtype: begin
				case (ins.r.funct)
					fn_add:  r = {1'b1, ins.r.rd, a + b};
					fn_sub:  r = {1'b1, ins.r.rd, a - b};
					fn_and:  r = {1'b1, ins.r.rd, a & b};
					fn_or:   r = {1'b1, ins.r.rd, a | b};
					fn_slt:  r = {1'b1, ins.r.rd, 31'b0, $signed(a) < $signed(b)};
					fn_jr:   npc = a;
					fn_mult: {m_hi, m_lo} = $signed(a) * $signed(b);	// 64 bit product
					fn_div: begin
						if (b != 32'd0) begin
							m_lo = $signed(a) / $signed(b);
							m_hi = $signed(a) % $signed(b);
						end
					end
					fn_mfhi: r = {1'b1, ins.r.rd, m_hi};
					fn_mflo: r = {1'b1, ins.r.rd, m_lo};
					fn_movn: if (b != 32'd0) r = {1'b1, ins.r.rd, a};
					default: ;
				endcase
			end
			op_addi: r = {1'b1, ins.i.rt, a + simm};
			op_slti: r = {1'b1, ins.i.rt, 31'b0, $signed(a) < $signed(simm)};
			op_andi: r = {1'b1, ins.i.rt, a & zimm};
			op_ori:  r = {1'b1, ins.i.rt, a | zimm};
			op_lui:  r = {1'b1, ins.i.rt, ins.i.imm16, 16'b0};
			op_lw:   r = {1'b1, ins.i.rt, m_dmem[widx]};
			op_lb:   r = {1'b1, ins.i.rt, 24'b0, m_dmem[widx][7:0]};	// Low byte only
			op_sw:   m_dmem[widx] = b;
			op_sb:   m_dmem[widx] = {24'b0, b[7:0]};
			op_beq:  if (a == b) npc = npc + {simm[29:0], 2'b00};
			op_bne:  if (a != b) npc = npc + {simm[29:0], 2'b00};
			op_j:    npc = {npc[31:28], ins.j.target26, 2'b00};
			op_jal: begin
				r   = {1'b1, 5'd31, npc};			// Link is pc+4
				npc = {npc[31:28], ins.j.target26, 2'b00};
			end
			default: ;
		endcase
		if (r.valid && r.reg_addr != 5'd0) begin
			m_regs[r.reg_addr] = r.data;		// r0 stays zero
		end
		m_pc = npc;
		return r;
	endfunction

	// Holds the core in reset for 4 cycles, loading prog first when asked
	task automatic reset_core(string name, bit load);
		@(posedge clk);
		rst_n <= 1'b0;
		if (load) begin
			foreach (prog[i]) begin
				prog_we   <= 1'b1;
				prog_addr <= imem_addr_w'(i);
				prog_data <= prog[i];
				@(posedge clk);
			end
			prog_we <= 1'b0;
		end
		repeat (4) begin
			@(negedge clk);
			if (retire.valid !== 1'b0 || pc !== 32'd0) begin
				$display("%s: core not idle in reset, pc %h and retire valid %b",
					name, pc, retire.valid);
				errors++;
			end
			@(posedge clk);
		end
		rst_n  <= 1'b1;
		m_regs = '{default: '0};
		m_hi   = '0;
		m_lo   = '0;
		m_pc   = '0;
	endtask

	// Compares pc, retire beat and hi/lo with the model, mid-cycle
	task automatic run_cycles(string name, int n);
		retire_t     exp;
		logic [31:0] exp_pc;
		logic [31:0] exp_hi;
		logic [31:0] exp_lo;
		repeat (n) begin
			@(negedge clk);
			exp_pc = m_pc;
			exp_hi = m_hi;
			exp_lo = m_lo;
			exp    = model_step();
			if (pc !== exp_pc) begin
				$display("mismatch %s pc: expected %h, actual %h", name, exp_pc, pc);
				errors++;
			end
			if (exp.valid && retire.valid !== 1'b1) begin
				$display("%s: nothing retired at pc %h, a write to r%0d was due",
					name, exp_pc, exp.reg_addr);
				errors++;
			end else if (!exp.valid && retire.valid !== 1'b0) begin
				$display("%s: unexpected write to r%0d retired at pc %h",
					name, retire.reg_addr, exp_pc);
				errors++;
			end else if (exp.valid && retire !== exp) begin
				$display("mismatch %s retire: expected r%0d=%h, actual r%0d=%h",
					name, exp.reg_addr, exp.data, retire.reg_addr, retire.data);
				errors++;
			end
			if (hi !== exp_hi || lo !== exp_lo) begin
				$display("mismatch %s hi/lo: expected %h/%h, actual %h/%h",
					name, exp_hi, exp_lo, hi, lo);
				errors++;
			end
		end
	endtask

	task automatic finish_test(string name, int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic run_test(string name, int cycles);
		int start;
		start = errors;
		reset_core(name, 1'b1);
		run_cycles(name, cycles);
		finish_test(name, start);
	endtask

	task automatic test_arith();
		arith_program($urandom(), $urandom(), 16'($urandom()));
		run_test("arith", arith_cycles);
	endtask

	task automatic test_memory();
		memory_program($urandom(), $urandom());
		run_test("memory", mem_cycles);
	endtask

	task automatic test_flow();
		flow_program($urandom() | 32'd1);
		run_test("flow", flow_cycles);
	endtask

	task automatic test_muu();
		muu_program($urandom(), $urandom() | 32'd1);
		run_test("muu", muu_cycles);
	endtask

	task automatic test_movn();
		movn_program($urandom(), $urandom() | 32'd1);
		run_test("movn", movn_cycles);
	endtask

	// Reset lands partway through the constant planting
	task automatic test_reset();
		int start;
		start = errors;
		reset_program($urandom() | 32'd1, $urandom() | 32'd1);
		reset_core("reset", 1'b1);
		run_cycles("reset", 4);
		reset_core("reset", 1'b0);			// Program stays loaded
		run_cycles("reset", reset_cycles - 4);
		finish_test("reset", start);
	endtask

	initial begin
		void'($urandom(32'h69c2_1092));		// One seed for the whole run
		rst_n        = 1'b0;
		prog_we      = 1'b0;
		prog_addr    = '0;
		prog_data    = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_arith();
		test_memory();
		test_flow();
		test_muu();
		test_movn();
		test_reset();
		$display("tests %0d, with errors %0d, error lines %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * 100);
		$display("watchdog: run did not end within %0d cycles", watchdog_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
